/* dv/mipsCoreTb.sv */
// Testbench for the core: clock, reset, program ROM, data RAM model, reference model and checks.
`timescale 1ns/1ps
`include "core_consts.svh"

module mipsCoreTb;
    import isaPkg::*;

    localparam int RomWords = 64;
    localparam int RamWords = 64;
    localparam logic [5:0] CodeSpecial  = 6'h00;
    localparam logic [5:0] CodeSpecial2 = 6'h1C;
    localparam logic [5:0] CodeAddiu    = 6'h09;
    localparam logic [5:0] CodeLw       = 6'h23;
    localparam logic [5:0] CodeSw       = 6'h2B;
    localparam logic [5:0] CodeBeq      = 6'h04;
    localparam logic [5:0] CodeAddu     = 6'h21;
    localparam logic [5:0] CodeSubu     = 6'h23;
    localparam logic [5:0] CodeAnd      = 6'h24;
    localparam logic [5:0] CodeOr       = 6'h25;
    localparam logic [5:0] CodeSlt      = 6'h2A;
    localparam logic [5:0] CodeMul      = 6'h02;

    logic   Clock;
    logic   nReset;
    wordT   InstrMem, MemData, WriteData, RegData;
    regIdxT RegAddr;
    addrT   InstrAddr, MemAddr;
    logic   MemRead, MemWrite;

    wordT rom [0:RomWords-1];
    wordT ram [0:RamWords-1];
    wordT refRam [0:RamWords-1];
    wordT refRegs [0:`REG_COUNT-1];
    addrT fetchQueue [$];
    addrT loadQueue [$];
    addrT storeAddrQueue [$];
    wordT storeDataQueue [$];
    addrT expectedAddr;
    wordT expectedData;
    logic fetchDone = 1'b0;
    int   cycleLimit = 0;
    int   fetchErrors = 0;
    int   memErrors = 0;
    int   regErrors = 0;
    int   assertErrors = 0;

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    mipsCore u_mipsCore (
        .Clock     (Clock),
        .nReset    (nReset),
        .InstrMem  (InstrMem),
        .MemData   (MemData),
        .RegAddr   (RegAddr),
        .InstrAddr (InstrAddr),
        .MemAddr   (MemAddr),
        .WriteData (WriteData),
        .RegData   (RegData),
        .MemRead   (MemRead),
        .MemWrite  (MemWrite)
    );

    // Both memories answer in the same cycle.
    assign InstrMem = rom[InstrAddr[7:2]];
    assign MemData  = ram[MemAddr[7:2]];

    always @(posedge Clock) begin
        if (MemWrite) begin
            ram[MemAddr[7:2]] <= WriteData;
        end
    end

    function automatic wordT encodeR(int op, int rs, int rt, int rd, int funct);
        return {6'(op), 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(funct)};
    endfunction

    function automatic wordT encodeI(int op, int rs, int rt, int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic wordT fillWord(int index);
        return wordT'(32'hA5000000 + index * 32'h00010101);
    endfunction

    task automatic reportMismatch(input string testName, input wordT expected, input wordT actual);
        $display("[ERROR] %s: expected %h, actual %h", testName, expected, actual);
    endtask

    task automatic writeRef(input regIdxT index, input wordT value);
        if (index != '0) begin
            refRegs[index] = value;
        end
    endtask

    task automatic loadProgram();
        int immA;
        int immB;
        int immNeg;
        immA   = int'($urandom_range(32767, 1));
        immB   = int'($urandom_range(32767, 1));
        immNeg = -int'($urandom_range(32768, 2));
        for (int i = 0; i < RamWords; i++) begin
            ram[i] <= fillWord(i);
            refRam[i] = fillWord(i);
        end
        for (int i = 0; i < RomWords; i++) begin
            rom[i] = '0;
        end
        // Dependent ALU chain, each result used by the next instruction.
        rom[0]  = encodeI(CodeAddiu, 0, 1, immA);
        rom[1]  = encodeI(CodeAddiu, 1, 2, immB);
        rom[2]  = encodeR(CodeSpecial, 1, 2, 3, CodeAddu);
        rom[3]  = encodeR(CodeSpecial, 1, 3, 4, CodeSubu);
        rom[4]  = encodeR(CodeSpecial, 4, 3, 5, CodeAnd);
        rom[5]  = encodeR(CodeSpecial, 5, 2, 6, CodeOr);
        rom[6]  = encodeR(CodeSpecial, 4, 3, 7, CodeSlt);
        rom[7]  = encodeR(CodeSpecial, 3, 4, 8, CodeSlt);
        // Multiplies with a negative operand and a dependent chain.
        rom[8]  = encodeI(CodeAddiu, 0, 9, immNeg);
        rom[9]  = encodeR(CodeSpecial2, 9, 1, 10, CodeMul);
        rom[10] = encodeR(CodeSpecial2, 10, 10, 11, CodeMul);
        rom[11] = encodeR(CodeSpecial, 11, 9, 12, CodeAddu);
        rom[12] = encodeI(CodeSw, 0, 12, 16);
        rom[13] = encodeI(CodeLw, 0, 13, 16);
        rom[14] = encodeR(CodeSpecial, 13, 12, 14, CodeAddu);
        rom[15] = encodeI(CodeAddiu, 0, 0, 77);
        rom[16] = encodeR(CodeSpecial, 14, 14, 0, CodeAddu);
        // Not taken, then taken over two instructions, then the final loop.
        rom[17] = encodeI(CodeBeq, 1, 2, 5);
        rom[18] = encodeI(CodeBeq, 13, 12, 2);
        rom[19] = encodeI(CodeAddiu, 0, 15, 1);
        rom[20] = encodeI(CodeAddiu, 0, 16, 2);
        rom[21] = encodeI(CodeAddiu, 15, 17, 3);
        rom[22] = encodeI(CodeBeq, 0, 0, -1);
    endtask

    // Runs the program in order and records the expected fetch and memory traffic.
    task automatic runReferenceModel();
        addrT pc, target, dataAddr;
        wordT instr, a, b, immExt;
        longint product;
        logic done;
        pc   = `RESET_PC;
        done = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            refRegs[i] = '0;
        end
        while (!done && fetchQueue.size() < 4 * RomWords) begin
            instr    = rom[pc[7:2]];
            immExt   = {{16{instr[15]}}, instr[15:0]};
            a        = refRegs[instr[25:21]];
            b        = refRegs[instr[20:16]];
            dataAddr = addrT'(a + immExt);
            target   = pc + addrT'(4);
            fetchQueue.push_back(pc);
            case (instr[31:26])
                CodeSpecial: begin
                    case (instr[5:0])
                        CodeAddu: writeRef(instr[15:11], a + b);
                        CodeSubu: writeRef(instr[15:11], a - b);
                        CodeAnd:  writeRef(instr[15:11], a & b);
                        CodeOr:   writeRef(instr[15:11], a | b);
                        CodeSlt:  writeRef(instr[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                CodeSpecial2: begin
                    product = longint'($signed(a)) * longint'($signed(b));
                    if (instr[5:0] == CodeMul) begin
                        writeRef(instr[15:11], product[31:0]);
                    end
                end
                CodeAddiu: writeRef(instr[20:16], a + immExt);
                CodeLw: begin
                    loadQueue.push_back(dataAddr);
                    writeRef(instr[20:16], refRam[dataAddr[7:2]]);
                end
                CodeSw: begin
                    storeAddrQueue.push_back(dataAddr);
                    storeDataQueue.push_back(b);
                    refRam[dataAddr[7:2]] = b;
                end
                CodeBeq: begin
                    if (a == b) begin
                        target = pc + addrT'(4) + addrT'(immExt << 2);
                        // The two squashed fetches still show on InstrAddr.
                        fetchQueue.push_back(pc + addrT'(4));
                        fetchQueue.push_back(pc + addrT'(8));
                        if (target == pc) begin
                            fetchQueue.push_back(pc);
                            done = 1'b1;
                        end
                    end
                end
                default: ;
            endcase
            pc = target;
        end
    endtask

    always @(negedge Clock) begin
        if (nReset && fetchQueue.size() > 0) begin
            expectedAddr = fetchQueue.pop_front();
            assert (InstrAddr == expectedAddr) else begin
                fetchErrors++;
                reportMismatch("fetch address", wordT'(expectedAddr), wordT'(InstrAddr));
            end
            if (fetchQueue.size() == 0) begin
                fetchDone = 1'b1;
            end
        end
    end

    always @(negedge Clock) begin
        if (nReset && MemWrite) begin
            if (storeAddrQueue.size() == 0) begin
                memErrors++;
                $display("Store to address %h that the program does not make", MemAddr);
            end else begin
                expectedAddr = storeAddrQueue.pop_front();
                expectedData = storeDataQueue.pop_front();
                assert (MemAddr == expectedAddr) else begin
                    memErrors++;
                    reportMismatch("store address", wordT'(expectedAddr), wordT'(MemAddr));
                end
                assert (WriteData == expectedData) else begin
                    memErrors++;
                    reportMismatch("store data", expectedData, WriteData);
                end
            end
        end
        if (nReset && MemRead) begin
            if (loadQueue.size() == 0) begin
                memErrors++;
                $display("Load from address %h that the program does not make", MemAddr);
            end else begin
                expectedAddr = loadQueue.pop_front();
                assert (MemAddr == expectedAddr) else begin
                    memErrors++;
                    reportMismatch("load address", wordT'(expectedAddr), wordT'(MemAddr));
                end
            end
        end
    end

    resetState: assert property (@(posedge Clock)
        $rose(nReset) |-> (InstrAddr == `RESET_PC && !MemRead && !MemWrite))
        else begin
            assertErrors++;
            $display("Core left reset with a wrong fetch address or a memory strobe high");
        end

    zeroRegister: assert property (@(posedge Clock) disable iff (!nReset)
        (RegAddr == '0) |-> (RegData == '0))
        else begin
            assertErrors++;
            $display("Register r0 read back a nonzero value");
        end

    alignedAccess: assert property (@(posedge Clock) disable iff (!nReset)
        (MemRead || MemWrite) |-> (MemAddr[1:0] == 2'b00))
        else begin
            assertErrors++;
            $display("Data memory access to an address that is not word aligned");
        end

    // Watchdog.
    initial begin
        wait (cycleLimit > 0);
        repeat (cycleLimit) @(posedge Clock);
        $display("Watchdog expired after %0d cycles before the program finished", cycleLimit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int totalErrors;
        nReset  <= 1'b0;
        RegAddr <= '0;
        void'($urandom(39));
        loadProgram();
        runReferenceModel();
        cycleLimit = fetchQueue.size() + `REG_COUNT + 45;
        repeat (5) @(posedge Clock);
        nReset <= 1'b1;
        wait (fetchDone);
        // Read back every register through the debug port.
        for (int r = 0; r < `REG_COUNT; r++) begin
            @(posedge Clock);
            RegAddr <= regIdxT'(r);
            @(negedge Clock);
            assert (RegData == refRegs[r]) else begin
                regErrors++;
                reportMismatch($sformatf("register r%0d", r), refRegs[r], RegData);
            end
        end
        if (storeAddrQueue.size() != 0 || loadQueue.size() != 0) begin
            memErrors++;
            $display("Some loads or stores of the program never reached the data memory");
        end
        totalErrors = fetchErrors + memErrors + regErrors + assertErrors;
        $display("Error counts: fetch %0d, memory %0d, register %0d, assertion %0d",
                 fetchErrors, memErrors, regErrors, assertErrors);
        if (totalErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/instrDecoder.sv
logic/registerFile.sv
logic/integerAlu.sv
logic/splitMultiplier.sv
logic/mipsCore.sv
dv/mipsCoreTb.sv

/* logic/core_consts.svh */
// Data width, address width, register count and reset address macros.
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Width of a data word and of a register.
`define DATA_WIDTH 32

// Byte address width of the instruction and data ports.
`define ADDR_WIDTH 16

// Number of architectural registers, r0 included.
`define REG_COUNT 32

// Address of the first fetch after reset.
`define RESET_PC 16'h0000

`endif

/* logic/instrDecoder.sv */
// Instruction decoder: register fields, sign-extended immediate and pipeline control.
`timescale 1ns/1ps
`include "core_consts.svh"

module instrDecoder (
    input  isaPkg::wordT    Instruction,
    output isaPkg::regIdxT  RsAddr,
    output isaPkg::regIdxT  RtAddr,
    output isaPkg::regIdxT  RdAddr,
    output isaPkg::wordT    Immediate,
    output pipePkg::aluOpT  AluOp,
    output pipePkg::wbSrcT  WbSrc,
    output logic            AluSrcImm,
    output logic            RegWrite,
    output logic            MemRead,
    output logic            MemWrite,
    output logic            Branch
);
    import isaPkg::*;
    import pipePkg::*;

    opcodeT opcode;
    functT  funct;
    logic   destIsRt;

    assign opcode    = opcodeT'(Instruction[31:26]);
    assign funct     = functT'(Instruction[5:0]);
    assign RsAddr    = Instruction[25:21];
    assign RtAddr    = Instruction[20:16];
    assign Immediate = {{(`DATA_WIDTH-16){Instruction[15]}}, Instruction[15:0]};

    // I-type results go to rt, R-type results to rd.
    assign RdAddr = destIsRt ? Instruction[20:16] : Instruction[15:11];

    always_comb begin
        AluOp     = aluAdd;
        WbSrc     = srcAlu;
        AluSrcImm = 1'b0;
        RegWrite  = 1'b0;
        MemRead   = 1'b0;
        MemWrite  = 1'b0;
        Branch    = 1'b0;
        destIsRt  = 1'b0;
        case (opcode)
            opSpecial: begin
                RegWrite = 1'b1;
                case (funct)
                    fnAddu:  AluOp = aluAdd;
                    fnSubu:  AluOp = aluSub;
                    fnAnd:   AluOp = aluAnd;
                    fnOr:    AluOp = aluOr;
                    fnSlt:   AluOp = aluSlt;
                    default: RegWrite = 1'b0;
                endcase
            end
            opSpecial2: begin
                RegWrite = (funct == fnMul);
                WbSrc    = srcMul;
            end
            opAddiu: begin
                AluSrcImm = 1'b1;
                RegWrite  = 1'b1;
                destIsRt  = 1'b1;
            end
            opLw: begin
                AluSrcImm = 1'b1;
                RegWrite  = 1'b1;
                MemRead   = 1'b1;
                WbSrc     = srcLoad;
                destIsRt  = 1'b1;
            end
            opSw: begin
                AluSrcImm = 1'b1;
                MemWrite  = 1'b1;
            end
            opBeq: begin
                AluOp  = aluSub;
                Branch = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* logic/integerAlu.sv */
// Integer ALU: add, subtract, and, or, signed set-less-than and equality compare.
`timescale 1ns/1ps

module integerAlu (
    input  isaPkg::wordT   A,
    input  isaPkg::wordT   B,
    input  pipePkg::aluOpT AluOp,
    output isaPkg::wordT   Result,
    output logic           Equal
);
    import isaPkg::*;
    import pipePkg::*;

    always_comb begin
        case (AluOp)
            aluAdd:  Result = A + B;
            aluSub:  Result = A - B;
            aluAnd:  Result = A & B;
            aluOr:   Result = A | B;
            aluSlt:  Result = wordT'($signed(A) < $signed(B));
            default: Result = '0;
        endcase
    end

    // Branch decision for BEQ.
    assign Equal = (A == B);

    // Operation codes come from the decoder through the pipeline register.
    always_comb begin
        knownAluOp: assert final (AluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluSlt})
            else $error("ALU received an undefined operation %0d", AluOp);
    end

endmodule

/* logic/isaPkg.sv */
// Instruction-set types: data word, register index, address, opcode and function codes.
`include "core_consts.svh"

package isaPkg;

    typedef logic [`DATA_WIDTH-1:0] wordT;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;
    typedef logic [`ADDR_WIDTH-1:0] addrT;

    // Primary opcode, bits 31:26.
    typedef enum logic [5:0] {
        opSpecial  = 6'h00,
        opBeq      = 6'h04,
        opAddiu    = 6'h09,
        opSpecial2 = 6'h1C,
        opLw       = 6'h23,
        opSw       = 6'h2B
    } opcodeT;

    // Function field, bits 5:0. MUL lives under SPECIAL2.
    typedef enum logic [5:0] {
        fnMul  = 6'h02,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2A
    } functT;

endpackage

/* logic/mipsCore.sv */
// Four-stage core: program counter, pipeline registers, forwarding, branch flush, writeback.
`timescale 1ns/1ps
`include "core_consts.svh"

module mipsCore (
    input  logic           Clock,
    input  logic           nReset,
    input  isaPkg::wordT   InstrMem,
    input  isaPkg::wordT   MemData,
    input  isaPkg::regIdxT RegAddr,
    output isaPkg::addrT   InstrAddr,
    output isaPkg::addrT   MemAddr,
    output isaPkg::wordT   WriteData,
    output isaPkg::wordT   RegData,
    output logic           MemRead,
    output logic           MemWrite
);
    import isaPkg::*;
    import pipePkg::*;

    addrT   fdPc;
    wordT   fdInstr;
    logic   fdValid;
    logic   keepDecode;

    regIdxT decRsAddr, decRtAddr, decDest;
    wordT   decImm, rsData, rtData;
    aluOpT  decAluOp;
    wbSrcT  decWbSrc;
    logic   decAluSrcImm, decRegWrite, decMemRead, decMemWrite, decBranch;

    addrT   exPc;
    regIdxT exRsAddr, exRtAddr, exDest;
    wordT   exRsData, exRtData, exImm;
    aluOpT  exAluOp;
    wbSrcT  exWbSrc;
    logic   exAluSrcImm, exRegWrite, exMemRead, exMemWrite, exBranch;

    wordT   fwdRs, fwdRt, aluB, aluResult, mulProduct;
    logic   aluEqual, branchTaken;
    addrT   branchTarget;

    regIdxT wbDest;
    wordT   wbAluResult, wbStoreData, wbResult;
    wbSrcT  wbSource;
    logic   wbRegWrite, wbMemRead, wbMemWrite;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            InstrAddr <= `RESET_PC;
        end else if (branchTaken) begin
            InstrAddr <= branchTarget;
        end else begin
            InstrAddr <= InstrAddr + addrT'(4);
        end
    end

    // Fetch/Decode. A taken branch kills the word being fetched.
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            fdValid <= 1'b0;
        end else begin
            fdValid <= !branchTaken;
        end
    end

    always_ff @(posedge Clock) begin
        fdInstr <= InstrMem;
        fdPc    <= InstrAddr;
    end

    instrDecoder u_instrDecoder (
        .Instruction (fdInstr),
        .RsAddr      (decRsAddr),
        .RtAddr      (decRtAddr),
        .RdAddr      (decDest),
        .Immediate   (decImm),
        .AluOp       (decAluOp),
        .WbSrc       (decWbSrc),
        .AluSrcImm   (decAluSrcImm),
        .RegWrite    (decRegWrite),
        .MemRead     (decMemRead),
        .MemWrite    (decMemWrite),
        .Branch      (decBranch)
    );

    registerFile u_registerFile (
        .Clock       (Clock),
        .nReset      (nReset),
        .RsAddr      (decRsAddr),
        .RtAddr      (decRtAddr),
        .WriteAddr   (wbDest),
        .RegAddr     (RegAddr),
        .WriteEnable (wbRegWrite),
        .WriteData   (wbResult),
        .RsData      (rsData),
        .RtData      (rtData),
        .RegData     (RegData)
    );

    // Decode/Execute. Squashed instructions lose every side effect.
    assign keepDecode = fdValid && !branchTaken;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            exAluOp     <= aluAdd;
            exWbSrc     <= srcAlu;
            exAluSrcImm <= 1'b0;
            exRegWrite  <= 1'b0;
            exMemRead   <= 1'b0;
            exMemWrite  <= 1'b0;
            exBranch    <= 1'b0;
        end else begin
            exAluOp     <= decAluOp;
            exWbSrc     <= decWbSrc;
            exAluSrcImm <= decAluSrcImm;
            exRegWrite  <= decRegWrite && keepDecode;
            exMemRead   <= decMemRead && keepDecode;
            exMemWrite  <= decMemWrite && keepDecode;
            exBranch    <= decBranch && keepDecode;
        end
    end

    always_ff @(posedge Clock) begin
        exPc     <= fdPc;
        exRsAddr <= decRsAddr;
        exRtAddr <= decRtAddr;
        exDest   <= decDest;
        exRsData <= rsData;
        exRtData <= rtData;
        exImm    <= decImm;
    end

    // Writeback result bypasses into Execute.
    assign fwdRs = (wbRegWrite && wbDest != '0 && wbDest == exRsAddr) ? wbResult : exRsData;
    assign fwdRt = (wbRegWrite && wbDest != '0 && wbDest == exRtAddr) ? wbResult : exRtData;
    assign aluB  = exAluSrcImm ? exImm : fwdRt;

    integerAlu u_integerAlu (
        .A      (fwdRs),
        .B      (aluB),
        .AluOp  (exAluOp),
        .Result (aluResult),
        .Equal  (aluEqual)
    );

    splitMultiplier u_splitMultiplier (
        .Clock   (Clock),
        .nReset  (nReset),
        .A       (fwdRs),
        .B       (fwdRt),
        .Product (mulProduct)
    );

    assign branchTaken  = exBranch && aluEqual;
    assign branchTarget = exPc + addrT'(4) + {exImm[`ADDR_WIDTH-3:0], 2'b00};

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            wbSource   <= srcAlu;
            wbRegWrite <= 1'b0;
            wbMemRead  <= 1'b0;
            wbMemWrite <= 1'b0;
        end else begin
            wbSource   <= exWbSrc;
            wbRegWrite <= exRegWrite;
            wbMemRead  <= exMemRead;
            wbMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge Clock) begin
        wbDest      <= exDest;
        wbAluResult <= aluResult;
        wbStoreData <= fwdRt;
    end

    always_comb begin
        case (wbSource)
            srcMul:  wbResult = mulProduct;
            srcLoad: wbResult = MemData;
            default: wbResult = wbAluResult;
        endcase
    end

    // Data memory access happens in Writeback.
    assign MemAddr   = wbAluResult[`ADDR_WIDTH-1:0];
    assign WriteData = wbStoreData;
    assign MemRead   = wbMemRead;
    assign MemWrite  = wbMemWrite;

    memAccessExclusive: assert property (@(posedge Clock) disable iff (!nReset)
        !(MemRead && MemWrite))
        else $error("MemRead and MemWrite asserted in the same cycle");

endmodule

/* logic/pipePkg.sv */
// Pipeline control types: ALU operation and writeback source.
package pipePkg;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    // Result picked in Writeback.
    typedef enum logic [1:0] {
        srcAlu  = 2'd0,
        srcMul  = 2'd1,
        srcLoad = 2'd2
    } wbSrcT;

endpackage

/* logic/registerFile.sv */
// Register file with two read ports, a debug read port and write-through.
`timescale 1ns/1ps
`include "core_consts.svh"

module registerFile (
    input  logic           Clock,
    input  logic           nReset,
    input  isaPkg::regIdxT RsAddr,
    input  isaPkg::regIdxT RtAddr,
    input  isaPkg::regIdxT WriteAddr,
    input  isaPkg::regIdxT RegAddr,
    input  logic           WriteEnable,
    input  isaPkg::wordT   WriteData,
    output isaPkg::wordT   RsData,
    output isaPkg::wordT   RtData,
    output isaPkg::wordT   RegData
);
    import isaPkg::*;

    // r0 is cleared at reset and never written.
    wordT regs [0:`REG_COUNT-1];

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (WriteEnable && WriteAddr != '0) begin
            regs[WriteAddr] <= WriteData;
        end
    end

    // The register being written reads back its new value.
    function automatic wordT readPort(input regIdxT addr);
        if (WriteEnable && WriteAddr != '0 && addr == WriteAddr) begin
            return WriteData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        RsData  = readPort(RsAddr);
        RtData  = readPort(RtAddr);
        RegData = readPort(RegAddr);
    end

    // r0 reads zero on both operand ports, whatever is written to it.
    zeroStaysZero: assert property (@(posedge Clock) disable iff (!nReset)
        (RsAddr != '0 || RsData == '0) && (RtAddr != '0 || RtData == '0))
        else $error("r0 read back a nonzero value");

endmodule

/* logic/splitMultiplier.sv */
// Split multiplier: registered 16x16 partial products and their recombination.
`timescale 1ns/1ps
`include "core_consts.svh"

module splitMultiplier (
    input  logic         Clock,
    input  logic         nReset,
    input  isaPkg::wordT A,
    input  isaPkg::wordT B,
    output isaPkg::wordT Product
);
    import isaPkg::*;

    localparam int Half = `DATA_WIDTH / 2;

    typedef logic [2*`DATA_WIDTH-1:0] dwordT;

    wordT  partLoLo;
    wordT  partLoHi;
    wordT  partHiLo;
    wordT  partHiHi;
    dwordT fullProduct;

    // Execute stage.
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            partLoLo <= '0;
            partLoHi <= '0;
            partHiLo <= '0;
            partHiHi <= '0;
        end else begin
            partLoLo <= A[Half-1:0] * B[Half-1:0];
            partLoHi <= A[Half-1:0] * B[`DATA_WIDTH-1:Half];
            partHiLo <= A[`DATA_WIDTH-1:Half] * B[Half-1:0];
            partHiHi <= A[`DATA_WIDTH-1:Half] * B[`DATA_WIDTH-1:Half];
        end
    end

    // Writeback stage. The low word of a product is the same for signed
    // and unsigned operands, so MUL comes out exact.
    always_comb begin
        fullProduct = (dwordT'(partHiHi) << `DATA_WIDTH)
                    + (dwordT'(partLoHi) << Half)
                    + (dwordT'(partHiLo) << Half)
                    + dwordT'(partLoLo);
    end

    assign Product = fullProduct[`DATA_WIDTH-1:0];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the core and its testbench with Verilator, runs the simulation and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log
SIM_BIN=mipsCoreSim

verilator --binary --timing --assert -Wno-fatal --top-module mipsCoreTb \
    -f filelist.f -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
SIM_STATUS=$?
cat "$LOG_FILE"
if [ $SIM_STATUS -ne 0 ]; then
    echo "Simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG_FILE"; then
    exit 0
fi
exit 1
